// File: tinker.f
+incdir+hdl
+incdir+testbench
hdl/tinker_pkg.sv
hdl/tinker_alu.sv
hdl/tinker_regfile.sv
hdl/tinker_memory.sv
hdl/tinker_control.sv
hdl/tinker_host_axil.sv
hdl/tinker_top.sv
testbench/tinker_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tinker.f --top-module tinker_tb \
    -o tinker_sim || exit 1
result=$(./obj_dir/tinker_sim)
echo "$result"
echo "$result" | grep -qx "Everything OK" && echo "Simulation passed" || {
    echo "Simulation did not pass"
    exit 1
}

// File: testbench/tinker_tb_tests.svh
// Tinker directed tests

    logic [31:0] prog [$];      // Program image from address 0
    logic [63:0] expect_q [$];  // ALU results in slot order
    bit          hit_q [$];     // Marker slot written or skipped

    task automatic emit(input opcode_e op, input logic [4:0] rd, input logic [4:0] rs,
                        input logic [4:0] rt, input logic [11:0] lit);
        prog.push_back({op, rd, rs, rt, lit});
    endtask

    // Address n instructions past the next one emitted
    function automatic logic [11:0] pc_ahead(input int n);
        return 12'(4 * (prog.size() + n));
    endfunction

    task automatic write_dword(input logic [31:0] addr, input logic [63:0] data);
        axil_write(addr, data[63:32]);       // Big-endian with the high word first
        axil_write(addr + 4, data[31:0]);
    endtask

    task automatic read_dword(input logic [31:0] addr, output logic [63:0] data);
        logic [31:0] hi;
        logic [31:0] lo;
        axil_read(addr, hi, 0);
        axil_read(addr + 4, lo, 0);
        data = {hi, lo};
    endtask

    task automatic start_core();
        logic [31:0] status;
        axil_write(`TINKER_HOST_CSR_ADDR, 32'h1);
        do axil_read(`TINKER_HOST_CSR_ADDR, status, 0); while (!status[0]);  // Until halted
    endtask

    task automatic run_program();
        foreach (prog[i]) axil_write(32'(4 * i), prog[i]);
        start_core();
    endtask

    // ----------------------------------------------------------------------
    task automatic host_memory_readback();
        logic [31:0] words [8];
        logic [31:0] got;
        axil_read(`TINKER_HOST_CSR_ADDR, got, 0);
        check_value("status", got, 32'h0);  // Idle and not halted
        for (int k = 0; k < 8; k++) begin
            words[k] = next_random();
            axil_write(32'h1000 + 32'h1fc * k, words[k]);
        end
        for (int k = 0; k < 8; k++) begin
            axil_read(32'h1000 + 32'h1fc * k, got, 0);
            check_value($sformatf("mem[%h]", 32'h1000 + 32'h1fc * k), got, words[k]);
        end
        axil_read(32'h4000_1000, got, 0);   // Low bits alias the first word
        check_value("unmapped rdata", got, 32'h0);
        finish_test("host_memory");
    endtask

    // One op into r4 and r4 stored to the next result slot
    task automatic alu_case(input opcode_e op, input logic [4:0] rs, input logic [4:0] rt,
                            input logic [11:0] lit, input logic [63:0] expected);
        emit(op, 4, rs, rt, lit);
        emit(OP_STORE, 0, 4, 0, 12'h600 + 12'(8 * expect_q.size()));
        expect_q.push_back(expected);
    endtask

    task automatic alu_operations();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] got;
        logic [5:0]  sh;
        logic [5:0]  l_shr;
        logic [5:0]  l_shl;
        logic [11:0] l_add;
        logic [11:0] l_sub;
        logic [11:0] l_movi;
        a      = {next_random(), next_random()};
        b      = {next_random(), next_random()};
        sh     = 6'(next_random());
        l_shr  = 6'(next_random());
        l_shl  = 6'(next_random());
        l_add  = 12'(next_random()) | 12'h800;  // Negative after sign extension
        l_sub  = 12'(next_random()) | 12'h800;  // Still positive when zero extended
        l_movi = 12'(next_random());
        write_dword(32'h400, a);
        write_dword(32'h408, b);
        write_dword(32'h410, 64'(sh));
        prog.delete();
        expect_q.delete();
        emit(OP_LOAD, 1, 0, 0, 12'h400);
        emit(OP_LOAD, 2, 0, 0, 12'h408);
        emit(OP_LOAD, 3, 0, 0, 12'h410);
        alu_case(OP_ADD, 1, 2, 0, a + b);
        alu_case(OP_SUB, 1, 2, 0, a - b);
        alu_case(OP_AND, 1, 2, 0, a & b);
        alu_case(OP_OR, 1, 2, 0, a | b);
        alu_case(OP_XOR, 1, 2, 0, a ^ b);
        alu_case(OP_NOT, 1, 0, 0, ~a);
        alu_case(OP_SHFTR, 1, 3, 0, a >> sh);
        alu_case(OP_SHFTL, 1, 3, 0, a << sh);
        alu_case(OP_MOV, 2, 0, 0, b);
        // Literal forms read rd so r4 is preset first
        emit(OP_MOV, 4, 1, 0, 0);
        alu_case(OP_ADDI, 0, 0, l_add, a + {{52{l_add[11]}}, l_add});
        emit(OP_MOV, 4, 1, 0, 0);
        alu_case(OP_SUBI, 0, 0, l_sub, a - {52'b0, l_sub});
        emit(OP_MOV, 4, 1, 0, 0);
        alu_case(OP_SHFTRI, 0, 0, {6'b0, l_shr}, a >> l_shr);
        emit(OP_MOV, 4, 1, 0, 0);
        alu_case(OP_SHFTLI, 0, 0, {6'b0, l_shl}, a << l_shl);
        emit(OP_MOV, 4, 2, 0, 0);
        alu_case(OP_MOVI, 0, 0, l_movi, {b[63:12], l_movi});  // Low 12 bits replaced
        emit(OP_HALT, 0, 0, 0, 0);
        run_program();
        foreach (expect_q[k]) begin
            read_dword(32'h600 + 32'(8 * k), got);
            check_value($sformatf("mem[%h]", 32'h600 + 32'(8 * k)), got, expect_q[k]);
        end
        finish_test("alu");
    endtask

    task automatic load_store_offsets();
        logic [63:0] v1;
        logic [63:0] v2;
        logic [63:0] got;
        v1 = {next_random(), next_random()};
        v2 = {next_random(), next_random()};
        write_dword(32'h440, 64'h800);  // Base for r5
        write_dword(32'h7f8, v1);
        write_dword(32'h818, v2);
        write_dword(32'h810, 64'h0);
        write_dword(32'h7e8, 64'h0);
        prog.delete();
        emit(OP_LOAD, 5, 0, 0, 12'h440);
        emit(OP_LOAD, 6, 5, 0, 12'hff8);   // 0x800 - 8
        emit(OP_LOAD, 7, 5, 0, 12'h018);   // 0x800 + 0x18
        emit(OP_STORE, 5, 6, 0, 12'h010);
        emit(OP_STORE, 5, 7, 0, 12'hfe8);  // 0x800 - 0x18
        emit(OP_HALT, 0, 0, 0, 0);
        run_program();
        read_dword(32'h810, got);
        check_value("mem[00000810]", got, v1);
        read_dword(32'h7e8, got);
        check_value("mem[000007e8]", got, v2);
        finish_test("load_store");
    endtask

    task automatic emit_marker(input bit written);
        emit(OP_STORE, 0, 8, 0, 12'h700 + 12'(8 * hit_q.size()));
        hit_q.push_back(written);
    endtask

    // Each taken branch jumps over one marker store
    task automatic branch_skips();
        logic [63:0] marker;
        logic [63:0] got;
        marker = {next_random() | 32'h1, next_random()};
        write_dword(32'h448, marker);
        write_dword(32'h450, 64'd3);
        write_dword(32'h458, 64'hffff_ffff_ffff_fffb);  // -5
        prog.delete();
        hit_q.delete();
        emit(OP_LOAD, 8, 0, 0, 12'h448);
        emit(OP_LOAD, 10, 0, 0, 12'h450);
        emit(OP_LOAD, 11, 0, 0, 12'h458);
        emit(OP_MOV, 9, 0, 0, 0);
        emit(OP_MOVI, 9, 0, 0, pc_ahead(3));
        emit(OP_BR, 9, 0, 0, 0);
        emit_marker(0);
        emit_marker(1);
        emit(OP_MOVI, 9, 0, 0, 12'd8);
        emit(OP_BRR, 9, 0, 0, 0);
        emit_marker(0);
        emit_marker(1);
        emit(OP_BRRI, 0, 0, 0, 12'd8);
        emit_marker(0);
        emit_marker(1);
        emit(OP_MOVI, 9, 0, 0, pc_ahead(3));
        emit(OP_BRNZ, 9, 8, 0, 0);          // Marker nonzero
        emit_marker(0);
        emit_marker(1);
        emit(OP_MOVI, 9, 0, 0, pc_ahead(3));
        emit(OP_BRNZ, 9, 0, 0, 0);          // r0 is zero so it falls through
        emit_marker(1);
        emit_marker(1);
        emit(OP_MOVI, 9, 0, 0, pc_ahead(3));
        emit(OP_BRGT, 9, 10, 11, 0);        // 3 > -5 signed
        emit_marker(0);
        emit_marker(1);
        emit(OP_MOVI, 9, 0, 0, pc_ahead(3));
        emit(OP_BRGT, 9, 11, 10, 0);        // -5 > 3 fails
        emit_marker(1);
        emit_marker(1);
        emit(OP_HALT, 0, 0, 0, 0);
        foreach (hit_q[k]) write_dword(32'h700 + 32'(8 * k), {32'hdead_beef, 32'(k)});
        run_program();
        foreach (hit_q[k]) begin
            read_dword(32'h700 + 32'(8 * k), got);
            check_value($sformatf("mem[%h]", 32'h700 + 32'(8 * k)), got,
                        hit_q[k] ? marker : {32'hdead_beef, 32'(k)});
        end
        finish_test("branches");
    endtask

    task automatic halt_and_restart();
        logic [31:0] status;
        logic [63:0] got;
        prog.delete();
        emit(OP_ADDI, 12, 0, 0, 12'd1);  // r12 counts runs and is untouched so far
        emit(OP_STORE, 0, 12, 0, 12'h480);
        emit(OP_HALT, 0, 0, 0, 0);
        run_program();
        axil_read(`TINKER_HOST_CSR_ADDR, status, 0);
        check_value("status", status, 32'h1);
        read_dword(32'h480, got);
        check_value("mem[00000480]", got, 64'd1);
        start_core();
        read_dword(32'h480, got);
        check_value("mem[00000480]", got, 64'd2);
        finish_test("restart");
    endtask

    task automatic bus_backpressure();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] got;
        first  = next_random();
        second = next_random();
        write_request(32'h1800, first);  // Response left pending
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = 32'h1804;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = second;
        repeat (4) begin
            @(negedge clk);
            check_value("awready", axil_rsp.awready, 1'b0);
            check_value("wready", axil_rsp.wready, 1'b0);
            check_value("bvalid", axil_rsp.bvalid, 1'b1);
        end
        next_cycle();
        write_response();
        write_request(32'h1804, second);
        write_response();
        axil_read(32'h1800, got, 5);     // rready low for 5 cycles
        check_value("mem[00001800]", got, first);
        axil_read(32'h1804, got, 0);
        check_value("mem[00001804]", got, second);
        finish_test("backpressure");
    endtask

// File: testbench/tinker_tb.sv
// Tinker core testbench
`timescale 1ns/1ns
`include "tinker_macros.svh"

module tinker_tb import tinker_pkg::*; ();
    localparam int TEST_BUDGET    = 3000;                    // Upper bound of cycles per test
    localparam int TIMEOUT_CYCLES = 6 * TEST_BUDGET + 2000;  // Six tests plus reset slack

    logic        clk;
    logic        reset;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] seed = 32'h773b;
    int          cycles = 0;
    int          test_errors = 0;   // Failed checks in the running test
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tinker_top i_tinker_top (.clk, .reset, .axil_req, .axil_rsp);

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, no result after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        assert (got === expected) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %-12s %s, %0d failed checks", name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
        test_errors = 0;
    endtask

    // Inputs move 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // ----------------------------------------------------------------------
    // AXI4-Lite master
    task automatic write_request(input logic [31:0] addr, input logic [31:0] data);
        logic ready;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        do begin
            @(negedge clk);
            ready = axil_rsp.awready && axil_rsp.wready;
            next_cycle();         // Handshake edge once ready
        end while (!ready);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
    endtask

    task automatic write_response();
        logic seen;
        axil_req.bready = 1'b1;
        do begin
            @(negedge clk);
            seen = axil_rsp.bvalid;
            if (seen) check_value("bresp", axil_rsp.bresp, 2'b00);  // OKAY
            next_cycle();
        end while (!seen);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        write_request(addr, data);
        write_response();
    endtask

    // Hold gives the cycles with rready low and rdata stable
    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data, input int hold);
        logic seen;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        do begin
            @(negedge clk);
            seen = axil_rsp.arready;
            next_cycle();
        end while (!seen);
        axil_req.arvalid = 1'b0;
        axil_req.rready  = (hold == 0);
        do begin
            @(negedge clk);
        end while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        check_value("rresp", axil_rsp.rresp, 2'b00);
        repeat (hold) begin
            @(negedge clk);
            check_value("rvalid", axil_rsp.rvalid, 1'b1);
            check_value("rdata", axil_rsp.rdata, data);
            check_value("arready", axil_rsp.arready, 1'b0);  // Response still pending
        end
        if (hold != 0) begin
            next_cycle();
            axil_req.rready = 1'b1;
        end
        next_cycle();
        axil_req.rready = 1'b0;
    endtask

    `include "tinker_tb_tests.svh"

    // ----------------------------------------------------------------------
    // Sequence
    initial begin
        reset    = 1'b1;
        axil_req = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        host_memory_readback();
        alu_operations();
        load_store_offsets();
        branch_skips();
        halt_and_restart();
        bus_backpressure();
        $display("Summary: %0d tests, %0d failed, %0d failed checks",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end
endmodule

// File: hdl/tinker_top.sv
// Tinker core top level
`timescale 1ns/1ns
`include "tinker_macros.svh"

module tinker_top import tinker_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);
    state_e                    state;
    logic                      start;
    host_mem_t                 host_mem;
    logic [31:0]               host_rdata;
    logic [`TINKER_ADDR_W-1:0] fetch_addr;
    logic [`TINKER_ADDR_W-1:0] load_addr;
    logic [`TINKER_ILEN-1:0]   instr_word;
    instr_t                    instr;
    reg_idx_t                  rs_addr;
    reg_idx_t                  rt_addr;
    logic [`TINKER_XLEN-1:0]   rs_data;
    logic [`TINKER_XLEN-1:0]   rt_data;
    logic [`TINKER_XLEN-1:0]   alu_result;
    logic [`TINKER_XLEN-1:0]   load_data;
    store_t                    store;
    wb_t                       wb;

    // ----------------------------------------------------------------------
    // Host port
    tinker_host_axil i_host (
        .clk, .reset, .axil_req, .axil_rsp,
        .host(host_mem), .host_rdata, .start, .state
    );

    // ----------------------------------------------------------------------
    // Core
    tinker_control i_control (
        .clk, .reset, .start, .state, .fetch_addr, .instr_word, .instr,
        .rs_addr, .rt_addr, .rs_data, .rt_data, .alu_result,
        .load_data, .load_addr, .store, .wb
    );

    tinker_regfile i_regfile (.clk, .reset, .rs_addr, .rt_addr, .rs_data, .rt_data, .wb);

    tinker_alu i_alu (.instr, .op_a(rs_data), .op_b(rt_data), .result(alu_result));

    tinker_memory i_memory (
        .clk, .fetch_addr, .instr_word, .load_addr, .load_data, .store,
        .host(host_mem), .host_rdata
    );
endmodule

// File: hdl/tinker_host_axil.sv
// Tinker AXI4-Lite host port
`timescale 1ns/1ns
`include "tinker_macros.svh"

module tinker_host_axil import tinker_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    output host_mem_t   host,
    input  logic [31:0] host_rdata,
    output logic        start,   // Run pulse to the core
    input  state_e      state
);
    localparam int AW = $clog2(`TINKER_MEM_BYTES);

    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] status;
    logic [31:0] rd_word;

    // Aligned word inside the memory window
    function automatic logic in_mem(input logic [31:0] addr);
        return (addr < `TINKER_MEM_BYTES) && (addr[1:0] == 2'b00);
    endfunction

    // ----------------------------------------------------------------------
    // Handshakes, a write owns the memory port in its cycle
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_fire = axil_req.arvalid && !rvalid_q && !wr_fire;

    assign host.we    = wr_fire && in_mem(axil_req.awaddr);
    assign host.addr  = wr_fire ? axil_req.awaddr[AW-1:0] : axil_req.araddr[AW-1:0];
    assign host.wdata = axil_req.wdata;

    assign status  = {30'b0, (state != IDLE) && (state != HALT), state == HALT};
    assign rd_word = in_mem(axil_req.araddr) ? host_rdata :
                     (axil_req.araddr == `TINKER_HOST_CSR_ADDR) ? status : '0;

    assign axil_rsp.awready = !bvalid_q;
    assign axil_rsp.wready  = !bvalid_q;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.bresp   = 2'b00;      // OKAY
    assign axil_rsp.arready = !rvalid_q && !wr_fire;
    assign axil_rsp.rvalid  = rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = 2'b00;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            start    <= 1'b0;
        end else begin
            start <= wr_fire && (axil_req.awaddr == `TINKER_HOST_CSR_ADDR) && axil_req.wdata[0];
            if (wr_fire) bvalid_q <= 1'b1;
            else if (axil_req.bready) bvalid_q <= 1'b0;
            if (rd_fire) rvalid_q <= 1'b1;
            else if (axil_req.rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) rdata_q <= rd_word;  // Held until rready
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));
endmodule

// File: hdl/tinker_control.sv
// Tinker multi-cycle control
`timescale 1ns/1ns
`include "tinker_macros.svh"

module tinker_control import tinker_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,      // One-cycle pulse from host
    output state_e                    state,
    output logic [`TINKER_ADDR_W-1:0] fetch_addr, // PC
    input  logic [`TINKER_ILEN-1:0]   instr_word,
    output instr_t                    instr,      // Latched at end of FETCH
    output reg_idx_t                  rs_addr,
    output reg_idx_t                  rt_addr,
    input  logic [`TINKER_XLEN-1:0]   rs_data,
    input  logic [`TINKER_XLEN-1:0]   rt_data,
    input  logic [`TINKER_XLEN-1:0]   alu_result,
    input  logic [`TINKER_XLEN-1:0]   load_data,
    output logic [`TINKER_ADDR_W-1:0] load_addr,
    output store_t                    store,
    output wb_t                       wb
);
    logic [`TINKER_ADDR_W-1:0] pc;
    logic [`TINKER_ADDR_W-1:0] next_pc;
    logic [`TINKER_ADDR_W-1:0] lit_sx;    // Sign-extended literal
    logic [`TINKER_ADDR_W-1:0] mem_addr;  // Base register + literal
    logic [`TINKER_XLEN-1:0]   exec_q;    // ALU result or brgt outcome in bit 0
    logic [`TINKER_XLEN-1:0]   load_q;
    logic                      writes_rd;

    assign fetch_addr = pc;
    assign lit_sx     = {{(`TINKER_ADDR_W-12){instr.lit[11]}}, instr.lit};
    assign mem_addr   = rs_data[`TINKER_ADDR_W-1:0] + lit_sx;
    assign load_addr  = mem_addr;

    // ----------------------------------------------------------------------
    // Register read ports where rd doubles as a source for some opcodes
    always_comb begin
        rs_addr = instr.rs;
        rt_addr = instr.rt;
        case (instr.opcode)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOVI,
            OP_BR, OP_BRR: rs_addr = instr.rd;
            OP_BRNZ:       rt_addr = instr.rd;       // Target
            OP_BRGT: if (state == MEMORY) rs_addr = instr.rd;  // Target once compared
            OP_STORE: begin
                rs_addr = instr.rd;  // Base
                rt_addr = instr.rs;  // Data
            end
            default: ;
        endcase
    end

    // Branch target used at end of MEMORY
    always_comb begin
        next_pc = pc + 4;
        case (instr.opcode)
            OP_BR:   next_pc = rs_data[`TINKER_ADDR_W-1:0];
            OP_BRR:  next_pc = pc + rs_data[`TINKER_ADDR_W-1:0];
            OP_BRRI: next_pc = pc + lit_sx;
            OP_BRNZ: if (rs_data != '0) next_pc = rt_data[`TINKER_ADDR_W-1:0];
            OP_BRGT: if (exec_q[0]) next_pc = rs_data[`TINKER_ADDR_W-1:0];
            default: ;
        endcase
    end

    always_comb begin
        case (instr.opcode)
            OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
            OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MOV, OP_MOVI, OP_LOAD: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // Store in MEMORY and register write in WRITEBACK
    assign store.we   = (state == MEMORY) && (instr.opcode == OP_STORE);
    assign store.addr = mem_addr;
    assign store.data = rt_data;
    assign wb.we      = (state == WRITEBACK) && writes_rd;
    assign wb.idx     = instr.rd;
    assign wb.data    = (instr.opcode == OP_LOAD) ? load_q : exec_q;

    // ----------------------------------------------------------------------
    // State and PC
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            pc    <= `TINKER_PC_RESET;
        end else begin
            case (state)
                IDLE, HALT: if (start) begin
                    state <= FETCH;
                    pc    <= `TINKER_PC_RESET;  // Registers keep their values
                end
                FETCH:     state <= DECODE;
                DECODE:    state <= (instr.opcode == OP_HALT) ? HALT : EXECUTE;
                EXECUTE:   state <= MEMORY;
                MEMORY: begin
                    state <= WRITEBACK;
                    pc    <= next_pc;
                end
                WRITEBACK: state <= FETCH;
                default:   state <= IDLE;
            endcase
        end
    end

    // Stage latches
    always_ff @(posedge clk) begin
        if (state == FETCH) instr <= instr_t'(instr_word);
        if (state == EXECUTE)
            exec_q <= (instr.opcode == OP_BRGT) ?
                      {{(`TINKER_XLEN-1){1'b0}}, $signed(rs_data) > $signed(rt_data)} :
                      alu_result;
        if (state == MEMORY) load_q <= load_data;
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {IDLE, FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALT});
endmodule

// File: hdl/tinker_memory.sv
// Tinker big-endian byte memory
`timescale 1ns/1ns
`include "tinker_macros.svh"

module tinker_memory import tinker_pkg::*; (
    input  logic                      clk,
    input  logic [`TINKER_ADDR_W-1:0] fetch_addr,
    output logic [`TINKER_ILEN-1:0]   instr_word,
    input  logic [`TINKER_ADDR_W-1:0] load_addr,
    output logic [`TINKER_XLEN-1:0]   load_data,
    input  store_t                    store,
    input  host_mem_t                 host,
    output logic [31:0]               host_rdata
);
    localparam int AW = $clog2(`TINKER_MEM_BYTES);

    logic [7:0] mem [`TINKER_MEM_BYTES];

    // ----------------------------------------------------------------------
    // Reads, most significant byte at lowest address
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            instr_word[31-8*i -: 8] = mem[AW'(fetch_addr + i)];
            host_rdata[31-8*i -: 8] = mem[AW'(host.addr + i)];
        end
        for (int i = 0; i < 8; i++) begin
            load_data[`TINKER_XLEN-1-8*i -: 8] = mem[AW'(load_addr + i)];
        end
    end

    // ----------------------------------------------------------------------
    // Writes, core doubleword or host word
    always_ff @(posedge clk) begin
        if (store.we) begin
            for (int i = 0; i < 8; i++) begin
                mem[AW'(store.addr + i)] <= store.data[`TINKER_XLEN-1-8*i -: 8];
            end
        end
        if (host.we) begin
            for (int i = 0; i < 4; i++) begin
                mem[AW'(host.addr + i)] <= host.wdata[31-8*i -: 8];
            end
        end
    end

    // Store address comes from register plus literal
    a_store_in_range: assert property (@(posedge clk)
        store.we |-> (store.addr <= 32'(`TINKER_MEM_BYTES - 8)));
endmodule

// File: hdl/tinker_regfile.sv
// Tinker register file
`timescale 1ns/1ns
`include "tinker_macros.svh"

module tinker_regfile import tinker_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  reg_idx_t                rs_addr,
    input  reg_idx_t                rt_addr,
    output logic [`TINKER_XLEN-1:0] rs_data,
    output logic [`TINKER_XLEN-1:0] rt_data,
    input  wb_t                     wb
);
    logic [`TINKER_XLEN-1:0] regs [`TINKER_NREGS];

    // Two async read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // Single write port, r0 is an ordinary register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.idx] <= wb.data;
        end
    end
endmodule

// File: hdl/tinker_alu.sv
// Tinker integer ALU
`timescale 1ns/1ns
`include "tinker_macros.svh"

module tinker_alu import tinker_pkg::*; (
    input  instr_t                  instr,
    input  logic [`TINKER_XLEN-1:0] op_a,   // rs, or rd for literal forms
    input  logic [`TINKER_XLEN-1:0] op_b,   // rt
    output logic [`TINKER_XLEN-1:0] result
);
    logic [`TINKER_XLEN-1:0] lit_sx;
    logic [`TINKER_XLEN-1:0] lit_zx;

    assign lit_sx = {{(`TINKER_XLEN-12){instr.lit[11]}}, instr.lit};
    assign lit_zx = {{(`TINKER_XLEN-12){1'b0}}, instr.lit};

    always_comb begin
        case (instr.opcode)
            OP_ADD:    result = op_a + op_b;
            OP_ADDI:   result = op_a + lit_sx;
            OP_SUB:    result = op_a - op_b;
            OP_SUBI:   result = op_a - lit_zx;  // Unsigned literal
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;
            OP_SHFTR:  result = op_a >> op_b;
            OP_SHFTRI: result = op_a >> instr.lit;
            OP_SHFTL:  result = op_a << op_b;
            OP_SHFTLI: result = op_a << instr.lit;
            OP_MOV:    result = op_a;
            OP_MOVI:   result = {op_a[`TINKER_XLEN-1:12], instr.lit};  // Upper bits kept
            default:   result = '0;
        endcase
    end
endmodule

// File: hdl/tinker_pkg.sv
// Tinker shared types
`include "tinker_macros.svh"

package tinker_pkg;

    typedef logic [$clog2(`TINKER_NREGS)-1:0] reg_idx_t;

    // Kept opcodes, original encodings
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,  // pc = rd
        OP_BRR    = 5'h09,  // pc += rd
        OP_BRRI   = 5'h0a,  // pc += sext(L)
        OP_BRNZ   = 5'h0b,  // rs != 0 -> pc = rd
        OP_BRGT   = 5'h0e,  // rs > rt signed -> pc = rd
        OP_HALT   = 5'h0f,
        OP_LOAD   = 5'h10,  // rd = mem[rs + sext(L)]
        OP_MOV    = 5'h11,
        OP_MOVI   = 5'h12,  // low 12 bits of rd only
        OP_STORE  = 5'h13,  // mem[rd + sext(L)] = rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [11:0] lit;
    } instr_t;

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALT
    } state_e;

    typedef struct packed {
        logic                      we;
        logic [`TINKER_ADDR_W-1:0] addr;
        logic [`TINKER_XLEN-1:0]   data;
    } store_t;

    typedef struct packed {
        logic                    we;
        reg_idx_t                idx;
        logic [`TINKER_XLEN-1:0] data;
    } wb_t;

    // Host word access, addr is a word-aligned byte address
    typedef struct packed {
        logic                                 we;
        logic [$clog2(`TINKER_MEM_BYTES)-1:0] addr;
        logic [31:0]                          wdata;
    } host_mem_t;

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

// File: hdl/tinker_macros.svh
// Tinker core constants
`ifndef TINKER_MACROS_SVH
`define TINKER_MACROS_SVH

// Datapath widths
`define TINKER_XLEN      64
`define TINKER_ILEN      32
`define TINKER_ADDR_W    32

// Register file depth
`define TINKER_NREGS     32

// Byte memory, big-endian
`define TINKER_MEM_BYTES 8192

// First fetch after start
`define TINKER_PC_RESET  32'h0000_0000

// Host side run/status register
`define TINKER_HOST_CSR_ADDR 32'h8000_0000

`endif
